//--- exec_top.f
exec_isa_pkg.sv
exec_flow_pkg.sv
credit_fifo.sv
exec_alu.sv
exec_unit.sv
exec_tx_port.sv
exec_top.sv
tb_clock_gen.sv
exec_top_tb.sv

//--- Bender.yml
package:
  name: exec_top

sources:
  - exec_isa_pkg.sv
  - exec_flow_pkg.sv
  - credit_fifo.sv
  - exec_alu.sv
  - exec_unit.sv
  - exec_tx_port.sv
  - exec_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - exec_top_tb.sv

//--- exec_top_tb.sv
`timescale 1ns/1ps

module exec_top_tb;

  localparam int NUM_OPS = 400;

  logic        clock;
  logic        reset;
  logic        in_valid;
  logic [31:0] pc;
  logic [31:0] imm;
  logic [31:0] src1;
  logic [31:0] src2;
  logic [31:0] csr_src;
  logic [31:0] mem_rdata;
  logic [3:0]  alu_op;
  logic [1:0]  op2_sel;
  logic [2:0]  npc_sel;
  logic [2:0]  wb_sel;
  logic [1:0]  csr_op;
  logic        in_credit;
  logic        out_credit;
  logic        out_valid;
  logic [31:0] npc;
  logic [31:0] alu_result;
  logic [31:0] r_wdata;
  logic [31:0] csr_wdata1;
  logic [31:0] csr_wdata2;

  integer seed = 91293;
  int     err_count = 0;
  int     sent_count = 0;
  int     recv_count = 0;
  int     up_credits = exec_flow_pkg::ISSUE_DEPTH;
  int     credit_back = 0; // in_credit pulses seen
  int     owed_credits = 0; // results not yet credited back
  int     returned_count = 0;
  int     cycle_count = 0;
  int     credit_rate = 4;
  exec_flow_pkg::result_t expect_q[$];

  tb_clock_gen u_clock_gen (
    .clock(clock),
    .reset(reset)
  );

  exec_top u_exec_top (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .pc        (pc),
    .imm       (imm),
    .src1      (src1),
    .src2      (src2),
    .csr_src   (csr_src),
    .mem_rdata (mem_rdata),
    .alu_op    (alu_op),
    .op2_sel   (op2_sel),
    .npc_sel   (npc_sel),
    .wb_sel    (wb_sel),
    .csr_op    (csr_op),
    .in_credit (in_credit),
    .out_credit(out_credit),
    .out_valid (out_valid),
    .npc       (npc),
    .alu_result(alu_result),
    .r_wdata   (r_wdata),
    .csr_wdata1(csr_wdata1),
    .csr_wdata2(csr_wdata2)
  );

  task automatic stop_with_failure();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      err_count++;
      $display("ERROR time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] model_alu(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [4:0]  sh;
    logic        lt_s;
    logic        lt_u;
    logic [63:0] ext;
    sh   = b[4:0];
    lt_u = a < b;
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000); // flip sign bit for signed order
    ext  = {{32{a[31]}}, a} >> sh;
    case (op)
      exec_isa_pkg::ALU_ADD:  return a + b;
      exec_isa_pkg::ALU_SUB:  return a - b;
      exec_isa_pkg::ALU_AND:  return a & b;
      exec_isa_pkg::ALU_OR:   return a | b;
      exec_isa_pkg::ALU_XOR:  return a ^ b;
      exec_isa_pkg::ALU_SLL:  return a << sh;
      exec_isa_pkg::ALU_SRL:  return a >> sh;
      exec_isa_pkg::ALU_SRA:  return ext[31:0];
      exec_isa_pkg::ALU_SLT:  return {31'd0, lt_s};
      exec_isa_pkg::ALU_SLTU: return {31'd0, lt_u};
      exec_isa_pkg::ALU_BEQ:  return {31'd0, a == b};
      exec_isa_pkg::ALU_BNE:  return {31'd0, a != b};
      exec_isa_pkg::ALU_BLT:  return {31'd0, lt_s};
      exec_isa_pkg::ALU_BGE:  return {31'd0, !lt_s};
      exec_isa_pkg::ALU_BLTU: return {31'd0, lt_u};
      default:                return {31'd0, !lt_u}; // bgeu
    endcase
  endfunction

  function automatic exec_flow_pkg::result_t predict_result(
    input logic [31:0] f_pc,
    input logic [31:0] f_imm,
    input logic [31:0] f_src1,
    input logic [31:0] f_src2,
    input logic [31:0] f_csr,
    input logic [31:0] f_mem,
    input logic [3:0]  f_alu,
    input logic [1:0]  f_op2,
    input logic [2:0]  f_npc,
    input logic [2:0]  f_wb,
    input logic [1:0]  f_csr_op
  );
    exec_flow_pkg::result_t r;
    logic [31:0] b;
    logic [31:0] seq_pc;
    logic [31:0] tgt_pc;
    b = (f_op2 == 2'd0) ? f_src2 : (f_op2 == 2'd1) ? f_imm : (f_op2 == 2'd2) ? f_csr : 32'd0;
    r.alu_result = model_alu(f_alu, f_src1, b);
    seq_pc = f_pc + 32'd4;
    tgt_pc = f_pc + f_imm;
    case (f_npc)
      3'd0:    r.npc = seq_pc;
      3'd1:    r.npc = tgt_pc;
      3'd2:    r.npc = {r.alu_result[31:1], 1'b0};
      3'd3:    r.npc = r.alu_result[0] ? tgt_pc : seq_pc;
      3'd4:    r.npc = f_csr;
      default: r.npc = 32'd0;
    endcase
    case (f_wb)
      3'd0:    r.r_wdata = r.alu_result;
      3'd1:    r.r_wdata = seq_pc;
      3'd2:    r.r_wdata = tgt_pc;
      3'd3:    r.r_wdata = f_mem;
      3'd4:    r.r_wdata = f_csr;
      default: r.r_wdata = 32'd0;
    endcase
    r.csr_wdata1 = 32'd0;
    r.csr_wdata2 = 32'd0;
    if (f_csr_op == exec_isa_pkg::CSR_WRITE) begin
      r.csr_wdata1 = r.alu_result;
    end else if (f_csr_op == exec_isa_pkg::CSR_ECALL) begin
      r.csr_wdata1 = 32'd11; // ecall cause
      r.csr_wdata2 = f_pc;
    end
    return r;
  endfunction

  task automatic drive_issue();
    logic [31:0] sel;
    sel       = $random(seed);
    pc        = $random(seed);
    imm       = $random(seed);
    src1      = $random(seed);
    src2      = $random(seed);
    csr_src   = $random(seed);
    mem_rdata = $random(seed);
    if (sel[15:14] == 2'd0) begin
      src2 = src1; // equal operands for beq, bge
    end
    alu_op  = sel[3:0];
    op2_sel = sel[5:4];
    npc_sel = sel[8:6];
    wb_sel  = sel[11:9];
    csr_op  = sel[13:12];
    expect_q.push_back(predict_result(pc, imm, src1, src2, csr_src, mem_rdata,
                                      alu_op, op2_sel, npc_sel, wb_sel, csr_op));
    in_valid = 1'b1;
  endtask

  // outputs are sampled mid-cycle, away from the clock edge
  always @(negedge clock) begin
    if (!reset) begin
      if (sent_count == 0) begin
        check_value("in_credit", 32'd0, {31'd0, in_credit});
        check_value("out_valid", 32'd0, {31'd0, out_valid});
      end
      if (in_credit) begin
        up_credits++;
        credit_back++;
        if (credit_back > sent_count) begin
          $display("in_credit returned more credits than operations were sent");
          stop_with_failure();
        end
      end
      if (out_valid) begin
        if (expect_q.size() == 0) begin
          $display("out_valid seen with no operation outstanding");
          stop_with_failure();
        end else begin
          exec_flow_pkg::result_t exp;
          exp = expect_q.pop_front();
          check_value("npc", exp.npc, npc);
          check_value("alu_result", exp.alu_result, alu_result);
          check_value("r_wdata", exp.r_wdata, r_wdata);
          check_value("csr_wdata1", exp.csr_wdata1, csr_wdata1);
          check_value("csr_wdata2", exp.csr_wdata2, csr_wdata2);
          recv_count++;
          owed_credits++;
          // a credit driven this cycle is not sampled by the DUT yet
          if (recv_count > returned_count - int'(out_credit) + exec_flow_pkg::OUT_CREDITS) begin
            $display("out_valid pulsed without a downstream credit");
            stop_with_failure();
          end
        end
      end
    end
  end

  initial begin
    in_valid   = 1'b0;
    pc         = '0;
    imm        = '0;
    src1       = '0;
    src2       = '0;
    csr_src    = '0;
    mem_rdata  = '0;
    alu_op     = '0;
    op2_sel    = '0;
    npc_sel    = '0;
    wb_sel     = '0;
    csr_op     = '0;
    out_credit = 1'b0;
    @(negedge reset);
    while (recv_count < NUM_OPS) begin
      @(posedge clock);
      #1;
      in_valid   = 1'b0;
      out_credit = 1'b0;
      cycle_count++;
      if (cycle_count % 50 == 0) begin
        credit_rate = $random(seed) & 7; // 0 withholds all credits for a while
      end
      if (sent_count < NUM_OPS && up_credits > 0 && ($random(seed) & 3) != 0) begin
        drive_issue();
        up_credits--;
        sent_count++;
      end
      if (owed_credits > 0 && ($random(seed) & 7) < credit_rate) begin
        out_credit = 1'b1;
        owed_credits--;
        returned_count++;
      end
    end
    @(posedge clock);
    #1;
    in_valid   = 1'b0;
    out_credit = 1'b0;
    repeat (8) @(posedge clock); // no stray results may follow
    check_value("in_credit_total", sent_count, credit_back);
    if (err_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

  initial begin
    repeat (NUM_OPS * 40) @(posedge clock);
    $display("timeout: not all %0d results arrived within %0d cycles", NUM_OPS, NUM_OPS * 40);
    stop_with_failure();
  end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock; // 20 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

//--- exec_top.sv
`timescale 1ns/1ps

module exec_top (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               in_valid,
  input  logic [exec_isa_pkg::XLEN-1:0]      pc,
  input  logic [exec_isa_pkg::XLEN-1:0]      imm,
  input  logic [exec_isa_pkg::XLEN-1:0]      src1,
  input  logic [exec_isa_pkg::XLEN-1:0]      src2,
  input  logic [exec_isa_pkg::XLEN-1:0]      csr_src,
  input  logic [exec_isa_pkg::XLEN-1:0]      mem_rdata,
  input  logic [exec_isa_pkg::ALU_OP_W-1:0]  alu_op,
  input  logic [exec_isa_pkg::OP2_SEL_W-1:0] op2_sel,
  input  logic [exec_isa_pkg::NPC_SEL_W-1:0] npc_sel,
  input  logic [exec_isa_pkg::WB_SEL_W-1:0]  wb_sel,
  input  logic [exec_isa_pkg::CSR_OP_W-1:0]  csr_op,
  output logic                               in_credit,
  input  logic                               out_credit,
  output logic                               out_valid,
  output logic [exec_isa_pkg::XLEN-1:0]      npc,
  output logic [exec_isa_pkg::XLEN-1:0]      alu_result,
  output logic [exec_isa_pkg::XLEN-1:0]      r_wdata,
  output logic [exec_isa_pkg::XLEN-1:0]      csr_wdata1,
  output logic [exec_isa_pkg::XLEN-1:0]      csr_wdata2
);

  exec_flow_pkg::issue_t  issue_in;
  exec_flow_pkg::issue_t  issue_head;
  logic                   issue_nonempty;
  logic                   issue_pop;
  exec_flow_pkg::result_t res_data;
  exec_flow_pkg::result_t res_head;
  logic                   res_push;
  logic                   res_pop;
  logic                   res_nonempty;
  logic                   res_credit;

  assign issue_in = '{pc: pc, imm: imm, src1: src1, src2: src2, csr_src: csr_src,
                      mem_rdata: mem_rdata, alu_op: alu_op, op2_sel: op2_sel,
                      npc_sel: npc_sel, wb_sel: wb_sel, csr_op: csr_op};

  credit_fifo #(
    .payload_t(exec_flow_pkg::issue_t),
    .DEPTH    (exec_flow_pkg::ISSUE_DEPTH)
  ) u_issue_fifo (
    .clock    (clock),
    .reset    (reset),
    .push     (in_valid),
    .push_data(issue_in),
    .pop      (issue_pop),
    .head     (issue_head),
    .nonempty (issue_nonempty),
    .credit   (in_credit) // back to upstream
  );

  exec_unit u_exec_unit (
    .clock     (clock),
    .reset     (reset),
    .head      (issue_head),
    .head_valid(issue_nonempty),
    .pop       (issue_pop),
    .res_push  (res_push),
    .res_data  (res_data),
    .res_credit(res_credit)
  );

  credit_fifo #(
    .payload_t(exec_flow_pkg::result_t),
    .DEPTH    (exec_flow_pkg::RESULT_DEPTH)
  ) u_result_fifo (
    .clock    (clock),
    .reset    (reset),
    .push     (res_push),
    .push_data(res_data),
    .pop      (res_pop),
    .head     (res_head),
    .nonempty (res_nonempty),
    .credit   (res_credit)
  );

  exec_tx_port u_tx_port (
    .clock       (clock),
    .reset       (reset),
    .res_head    (res_head),
    .res_nonempty(res_nonempty),
    .res_pop     (res_pop),
    .out_credit  (out_credit),
    .out_valid   (out_valid),
    .npc         (npc),
    .alu_result  (alu_result),
    .r_wdata     (r_wdata),
    .csr_wdata1  (csr_wdata1),
    .csr_wdata2  (csr_wdata2)
  );

endmodule

//--- exec_tx_port.sv
`timescale 1ns/1ps

module exec_tx_port (
  input  logic                          clock,
  input  logic                          reset,
  input  exec_flow_pkg::result_t        res_head,
  input  logic                          res_nonempty,
  output logic                          res_pop,
  input  logic                          out_credit,
  output logic                          out_valid,
  output logic [exec_isa_pkg::XLEN-1:0] npc,
  output logic [exec_isa_pkg::XLEN-1:0] alu_result,
  output logic [exec_isa_pkg::XLEN-1:0] r_wdata,
  output logic [exec_isa_pkg::XLEN-1:0] csr_wdata1,
  output logic [exec_isa_pkg::XLEN-1:0] csr_wdata2
);

  logic [exec_flow_pkg::OUT_CNT_W-1:0] credit_cnt;

  assign res_pop = res_nonempty && (credit_cnt != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      credit_cnt <= exec_flow_pkg::OUT_CNT_W'(exec_flow_pkg::OUT_CREDITS);
      out_valid  <= 1'b0;
    end else begin
      credit_cnt <= credit_cnt - exec_flow_pkg::OUT_CNT_W'(res_pop)
                    + exec_flow_pkg::OUT_CNT_W'(out_credit);
      out_valid  <= res_pop; // one-cycle pulse
    end
  end

  always_ff @(posedge clock) begin
    if (res_pop) begin
      npc        <= res_head.npc;
      alu_result <= res_head.alu_result;
      r_wdata    <= res_head.r_wdata;
      csr_wdata1 <= res_head.csr_wdata1;
      csr_wdata2 <= res_head.csr_wdata2;
    end
  end

  // downstream must not return more credits than it was given
  assert property (@(posedge clock) disable iff (reset)
    credit_cnt <= exec_flow_pkg::OUT_CNT_W'(exec_flow_pkg::OUT_CREDITS))
    else $error("exec_tx_port: downstream credit overflow");

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  exec_flow_pkg::issue_t  head,
  input  logic                   head_valid,
  output logic                   pop,
  output logic                   res_push,
  output exec_flow_pkg::result_t res_data,
  input  logic                   res_credit
);

  logic [exec_isa_pkg::XLEN-1:0]        operand2;
  logic [exec_isa_pkg::XLEN-1:0]        alu_result;
  logic [exec_isa_pkg::XLEN-1:0]        snpc;
  logic [exec_isa_pkg::XLEN-1:0]        dnpc;
  logic [exec_isa_pkg::XLEN-1:0]        npc;
  logic [exec_isa_pkg::XLEN-1:0]        r_wdata;
  logic [exec_isa_pkg::XLEN-1:0]        csr_wdata1;
  logic [exec_isa_pkg::XLEN-1:0]        csr_wdata2;
  logic [exec_flow_pkg::RES_CNT_W-1:0] credit_cnt;

  always_comb begin
    case (head.op2_sel)
      exec_isa_pkg::OP2_SRC2: operand2 = head.src2;
      exec_isa_pkg::OP2_IMM:  operand2 = head.imm;
      exec_isa_pkg::OP2_CSR:  operand2 = head.csr_src;
      exec_isa_pkg::OP2_ZERO: operand2 = '0;
      default:                operand2 = '0;
    endcase
  end

  exec_alu u_alu (
    .alu_op  (head.alu_op),
    .operand1(head.src1),
    .operand2(operand2),
    .result  (alu_result)
  );

  assign snpc = head.pc + 32'd4;
  assign dnpc = head.pc + head.imm;

  always_comb begin
    case (head.npc_sel)
      exec_isa_pkg::NPC_SNPC:   npc = snpc;
      exec_isa_pkg::NPC_JAL:    npc = dnpc;
      exec_isa_pkg::NPC_JALR:   npc = alu_result & ~32'd1;
      exec_isa_pkg::NPC_BRANCH: npc = alu_result[0] ? dnpc : snpc; // taken when cond is 1
      exec_isa_pkg::NPC_CSR:    npc = head.csr_src;
      default:                  npc = '0;
    endcase
  end

  always_comb begin
    case (head.wb_sel)
      exec_isa_pkg::WB_ALU:  r_wdata = alu_result;
      exec_isa_pkg::WB_SNPC: r_wdata = snpc;
      exec_isa_pkg::WB_DNPC: r_wdata = dnpc;
      exec_isa_pkg::WB_MEM:  r_wdata = head.mem_rdata;
      exec_isa_pkg::WB_CSR:  r_wdata = head.csr_src;
      default:               r_wdata = '0;
    endcase
  end

  always_comb begin
    case (head.csr_op)
      exec_isa_pkg::CSR_NONE: begin
        csr_wdata1 = '0;
        csr_wdata2 = '0;
      end
      exec_isa_pkg::CSR_WRITE: begin
        csr_wdata1 = alu_result;
        csr_wdata2 = '0;
      end
      exec_isa_pkg::CSR_ECALL: begin
        csr_wdata1 = exec_isa_pkg::ECALL_CAUSE; // mcause
        csr_wdata2 = head.pc; // mepc
      end
      default: begin
        csr_wdata1 = '0;
        csr_wdata2 = '0;
      end
    endcase
  end

  assign pop = head_valid && (credit_cnt != '0); // only with room downstream

  always_ff @(posedge clock) begin
    if (reset) begin
      credit_cnt <= exec_flow_pkg::RES_CNT_W'(exec_flow_pkg::RESULT_DEPTH);
      res_push   <= 1'b0;
    end else begin
      credit_cnt <= credit_cnt - exec_flow_pkg::RES_CNT_W'(pop)
                    + exec_flow_pkg::RES_CNT_W'(res_credit);
      res_push   <= pop;
    end
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      res_data.npc        <= npc;
      res_data.alu_result <= alu_result;
      res_data.r_wdata    <= r_wdata;
      res_data.csr_wdata1 <= csr_wdata1;
      res_data.csr_wdata2 <= csr_wdata2;
    end
  end

  // result buffer returns no more credits than were spent
  assert property (@(posedge clock) disable iff (reset)
    credit_cnt <= exec_flow_pkg::RES_CNT_W'(exec_flow_pkg::RESULT_DEPTH))
    else $error("exec_unit: result credit overflow");

endmodule

//--- exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
  input  logic [exec_isa_pkg::ALU_OP_W-1:0] alu_op,
  input  logic [exec_isa_pkg::XLEN-1:0]     operand1,
  input  logic [exec_isa_pkg::XLEN-1:0]     operand2,
  output logic [exec_isa_pkg::XLEN-1:0]     result
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  assign shamt = operand2[4:0];
  assign eq    = (operand1 == operand2);
  assign lt    = ($signed(operand1) < $signed(operand2));
  assign ltu   = (operand1 < operand2);

  always_comb begin
    case (alu_op)
      exec_isa_pkg::ALU_ADD:  result = operand1 + operand2;
      exec_isa_pkg::ALU_SUB:  result = operand1 - operand2;
      exec_isa_pkg::ALU_AND:  result = operand1 & operand2;
      exec_isa_pkg::ALU_OR:   result = operand1 | operand2;
      exec_isa_pkg::ALU_XOR:  result = operand1 ^ operand2;
      exec_isa_pkg::ALU_SLL:  result = operand1 << shamt;
      exec_isa_pkg::ALU_SRL:  result = operand1 >> shamt;
      exec_isa_pkg::ALU_SRA:  result = $signed(operand1) >>> shamt;
      exec_isa_pkg::ALU_SLT:  result = exec_isa_pkg::XLEN'(lt);
      exec_isa_pkg::ALU_SLTU: result = exec_isa_pkg::XLEN'(ltu);
      exec_isa_pkg::ALU_BEQ:  result = exec_isa_pkg::XLEN'(eq);
      exec_isa_pkg::ALU_BNE:  result = exec_isa_pkg::XLEN'(!eq);
      exec_isa_pkg::ALU_BLT:  result = exec_isa_pkg::XLEN'(lt);
      exec_isa_pkg::ALU_BGE:  result = exec_isa_pkg::XLEN'(!lt);
      exec_isa_pkg::ALU_BLTU: result = exec_isa_pkg::XLEN'(ltu);
      exec_isa_pkg::ALU_BGEU: result = exec_isa_pkg::XLEN'(!ltu);
      default:                result = '0;
    endcase
  end

endmodule

//--- credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     nonempty,
  output logic     credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      next_ptr = '0; // wrap
    end else begin
      next_ptr = ptr + 1'b1;
    end
  endfunction

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop; // one credit back per pop
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head     = mem[rd_ptr];
  assign nonempty = (count != '0);

  // the sender must never push without a credit
  assert property (@(posedge clock) disable iff (reset) push |-> (count < CNT_W'(DEPTH)))
    else $error("credit_fifo: push while full");

  assert property (@(posedge clock) disable iff (reset) pop |-> nonempty)
    else $error("credit_fifo: pop while empty");

endmodule

//--- exec_flow_pkg.sv
package exec_flow_pkg;

  localparam int ISSUE_DEPTH  = 4;
  localparam int RESULT_DEPTH = 4;
  localparam int OUT_CREDITS  = 2; // downstream credits at reset

  localparam int ISSUE_CNT_W = $clog2(ISSUE_DEPTH + 1);
  localparam int RES_CNT_W   = $clog2(RESULT_DEPTH + 1);
  localparam int OUT_CNT_W   = $clog2(OUT_CREDITS + 1);

  typedef struct packed {
    logic [exec_isa_pkg::XLEN-1:0]      pc;
    logic [exec_isa_pkg::XLEN-1:0]      imm;
    logic [exec_isa_pkg::XLEN-1:0]      src1;
    logic [exec_isa_pkg::XLEN-1:0]      src2;
    logic [exec_isa_pkg::XLEN-1:0]      csr_src;
    logic [exec_isa_pkg::XLEN-1:0]      mem_rdata;
    logic [exec_isa_pkg::ALU_OP_W-1:0]  alu_op;
    logic [exec_isa_pkg::OP2_SEL_W-1:0] op2_sel;
    logic [exec_isa_pkg::NPC_SEL_W-1:0] npc_sel;
    logic [exec_isa_pkg::WB_SEL_W-1:0]  wb_sel;
    logic [exec_isa_pkg::CSR_OP_W-1:0]  csr_op;
  } issue_t;

  typedef struct packed {
    logic [exec_isa_pkg::XLEN-1:0] npc;
    logic [exec_isa_pkg::XLEN-1:0] alu_result;
    logic [exec_isa_pkg::XLEN-1:0] r_wdata;
    logic [exec_isa_pkg::XLEN-1:0] csr_wdata1;
    logic [exec_isa_pkg::XLEN-1:0] csr_wdata2;
  } result_t;

endpackage

//--- exec_isa_pkg.sv
package exec_isa_pkg;

  localparam int XLEN = 32;

  localparam int ALU_OP_W  = 4;
  localparam int OP2_SEL_W = 2;
  localparam int NPC_SEL_W = 3;
  localparam int WB_SEL_W  = 3;
  localparam int CSR_OP_W  = 2;

  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;
  localparam logic [ALU_OP_W-1:0] ALU_BEQ  = 4'd10; // branch codes give 1 or 0
  localparam logic [ALU_OP_W-1:0] ALU_BNE  = 4'd11;
  localparam logic [ALU_OP_W-1:0] ALU_BLT  = 4'd12;
  localparam logic [ALU_OP_W-1:0] ALU_BGE  = 4'd13;
  localparam logic [ALU_OP_W-1:0] ALU_BLTU = 4'd14;
  localparam logic [ALU_OP_W-1:0] ALU_BGEU = 4'd15;

  localparam logic [OP2_SEL_W-1:0] OP2_SRC2 = 2'd0;
  localparam logic [OP2_SEL_W-1:0] OP2_IMM  = 2'd1; // most i-type
  localparam logic [OP2_SEL_W-1:0] OP2_CSR  = 2'd2; // csrrs, csrrc
  localparam logic [OP2_SEL_W-1:0] OP2_ZERO = 2'd3;

  localparam logic [NPC_SEL_W-1:0] NPC_SNPC   = 3'd0;
  localparam logic [NPC_SEL_W-1:0] NPC_JAL    = 3'd1;
  localparam logic [NPC_SEL_W-1:0] NPC_JALR   = 3'd2;
  localparam logic [NPC_SEL_W-1:0] NPC_BRANCH = 3'd3;
  localparam logic [NPC_SEL_W-1:0] NPC_CSR    = 3'd4; // ecall, mret

  localparam logic [WB_SEL_W-1:0] WB_ALU  = 3'd0;
  localparam logic [WB_SEL_W-1:0] WB_SNPC = 3'd1; // jal, jalr
  localparam logic [WB_SEL_W-1:0] WB_DNPC = 3'd2; // auipc
  localparam logic [WB_SEL_W-1:0] WB_MEM  = 3'd3; // load
  localparam logic [WB_SEL_W-1:0] WB_CSR  = 3'd4;

  localparam logic [CSR_OP_W-1:0] CSR_NONE  = 2'd0;
  localparam logic [CSR_OP_W-1:0] CSR_WRITE = 2'd1;
  localparam logic [CSR_OP_W-1:0] CSR_ECALL = 2'd2;

  localparam logic [XLEN-1:0] ECALL_CAUSE = 32'd11; // env call from m-mode

endpackage
